// ==== Makefile ====
# Verilator build and run of the JPEG entropy encoder testbench

VERILATOR ?= verilator
TOP       ?= jpeg_huffman_encode_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Finished with no errors

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh tb/*.sv tb/*.svh)

.PHONY: all build run check clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(BUILD_DIR) -o V$* -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/bitstream_packer.sv ====
`timescale 1ns/1ps
`include "jpeg_huffman_params.svh"

module bitstream_packer (
    input  logic                        clock,
    input  logic                        nreset,
    symbol_if.sink                      sym,
    table_lookup_if.reader              lookup,
    output logic                        output_wren,
    output jpeg_huffman_pkg::out_len_t  output_length,
    output jpeg_huffman_pkg::out_word_t output_data,
    output logic                        finished
);
    import jpeg_huffman_pkg::*;

    code_t     code_mask;
    code_t     value_bits;
    category_t value_len;
    logic      block_end;
    logic      word_last;

    ////////////////////////////////////////////////////////////////////////////
    // word assembly

    always_comb begin
        // a length of 16 wraps to an all ones mask
        code_mask = (code_t'(1) << lookup.rd_length) - 1'b1;

        // zrl and eob carry no value bits
        if (sym.kind == SYM_DC || sym.kind == SYM_AC) begin
            value_bits = sym.value_bits;
            value_len = sym.category;
        end else begin
            value_bits = '0;
            value_len = '0;
        end

        block_end = sym.valid
                    && (sym.kind == SYM_EOB || (sym.kind == SYM_AC && sym.is_last));
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            output_wren <= 1'b0;
            word_last <= 1'b0;
            finished <= 1'b0;
        end else begin
            output_wren <= sym.valid;
            word_last <= block_end;
            // rises the cycle after the last word of a block
            if (word_last) begin
                finished <= 1'b1;
            end else if (sym.valid) begin
                finished <= 1'b0;
            end
        end
        output_data <= out_word_t'(lookup.rd_code & code_mask)
                       | (out_word_t'(value_bits) << lookup.rd_length);
        output_length <= out_len_t'(lookup.rd_length) + out_len_t'(value_len);
    end

    assert property (@(posedge clock) disable iff (nreset)
                     output_wren |-> output_length <= `OUT_WIDTH)
        else $error("packed word longer than the output width");

endmodule

// ==== design/coefficient_categorizer.sv ====
`timescale 1ns/1ps
`include "jpeg_huffman_params.svh"

module coefficient_categorizer (
    input  logic                     clock,
    input  logic                     nreset,
    input  jpeg_huffman_pkg::index_t fetch_addr,
    input  logic                     fetch_valid,
    input  logic                     rollback,
    input  jpeg_huffman_pkg::coef_t  coef_data,
    coded_coef_if.source             coef
);
    import jpeg_huffman_pkg::*;

    index_t    addr_q;
    logic      valid_q;
    coef_t     dc_pred;
    coef_t     value;
    coef_t     magnitude;
    coef_t     adjusted;
    category_t category;
    code_t     value_mask;
    logic      is_dc;

    // number of significant bits in the magnitude
    function automatic category_t magnitude_category(input coef_t mag);
        category_t cat;
        cat = '0;
        for (int b = 0; b < `COEF_WIDTH; b++) begin
            if (mag[b]) begin
                cat = category_t'(b + 1);
            end
        end
        return cat;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // align address with the memory read data

    always_ff @(posedge clock) begin
        if (nreset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_valid & ~rollback;
        end
        addr_q <= fetch_addr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // dc differential and category coding

    always_comb begin
        is_dc = (addr_q == '0);
        value = is_dc ? coef_data - dc_pred : coef_data;
        magnitude = value[`COEF_WIDTH-1] ? -value : value;
        // negative values send the low bits of value minus one
        adjusted = value[`COEF_WIDTH-1] ? value - coef_t'(1) : value;
        category = magnitude_category(magnitude);
        value_mask = (code_t'(1) << category) - 1'b1;
    end

    // predictor carries over to the next block
    always_ff @(posedge clock) begin
        if (nreset) begin
            dc_pred <= '0;
        end else if (valid_q && is_dc && !rollback) begin
            dc_pred <= coef_data;
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            coef.valid <= 1'b0;
        end else begin
            coef.valid <= valid_q & ~rollback;
        end
        coef.is_dc <= is_dc;
        coef.is_last <= (addr_q == index_t'(`BLOCK_LEN - 1));
        coef.index <= addr_q;
        coef.value_bits <= code_t'(adjusted) & value_mask;
        coef.category <= category;
    end

endmodule

// ==== design/coefficient_fetch.sv ====
`timescale 1ns/1ps
`include "jpeg_huffman_params.svh"

module coefficient_fetch (
    input  logic                     clock,
    input  logic                     nreset,
    input  logic                     start,
    input  logic                     rollback,
    input  jpeg_huffman_pkg::index_t rollback_index,
    output jpeg_huffman_pkg::index_t fetch_addr,
    output logic                     fetch_valid
);
    import jpeg_huffman_pkg::*;

    fetch_state_t state;
    index_t       index;

    always_ff @(posedge clock) begin
        if (nreset) begin
            state <= FETCH_IDLE;
            index <= '0;
        end else if (rollback) begin
            // refetch after the sixteenth zero, even when the sweep already ended
            state <= FETCH_RUN;
            index <= rollback_index;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (start) begin
                        state <= FETCH_RUN;
                        index <= '0;
                    end
                end
                FETCH_RUN: begin
                    if (index == index_t'(`BLOCK_LEN - 1)) begin
                        state <= FETCH_IDLE;
                    end else begin
                        index <= index + 1'b1;
                    end
                end
            endcase
        end
    end

    assign fetch_addr = index;
    assign fetch_valid = (state == FETCH_RUN);

    // a new block may only start once the previous sweep is done
    assert property (@(posedge clock) disable iff (nreset) start |-> state == FETCH_IDLE)
        else $error("start while a block is being fetched");

endmodule

// ==== design/huffman_table_store.sv ====
`timescale 1ns/1ps
`include "jpeg_huffman_params.svh"

module huffman_table_store (
    input  logic                          clock,
    input  logic                          table_wren,
    input  jpeg_huffman_pkg::table_addr_t table_waddr,
    input  jpeg_huffman_pkg::code_t       table_wcode,
    input  jpeg_huffman_pkg::code_len_t   table_wlength,
    table_lookup_if.responder             lookup
);
    import jpeg_huffman_pkg::*;

    // lower half dc by category, upper half ac by run/size symbol
    localparam int TABLE_DEPTH = 2 ** `TABLE_ADDR_WIDTH;

    code_t     code_mem [TABLE_DEPTH];
    code_len_t length_mem [TABLE_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // host load port

    always_ff @(posedge clock) begin
        if (table_wren) begin
            code_mem[table_waddr] <= table_wcode;
            length_mem[table_waddr] <= table_wlength;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registered read, block ram style

    always_ff @(posedge clock) begin
        lookup.rd_code <= code_mem[lookup.rd_addr];
        lookup.rd_length <= length_mem[lookup.rd_addr];
    end

endmodule

// ==== design/jpeg_huffman_encode.sv ====
`timescale 1ns/1ps

module jpeg_huffman_encode (
    input  logic                          clock,
    input  logic                          nreset,
    input  logic                          start,
    output jpeg_huffman_pkg::index_t      fetch_addr,
    input  jpeg_huffman_pkg::coef_t       coef_data,
    input  logic                          table_wren,
    input  jpeg_huffman_pkg::table_addr_t table_waddr,
    input  jpeg_huffman_pkg::code_t       table_wcode,
    input  jpeg_huffman_pkg::code_len_t   table_wlength,
    output logic                          output_wren,
    output jpeg_huffman_pkg::out_len_t    output_length,
    output jpeg_huffman_pkg::out_word_t   output_data,
    output logic                          finished
);
    import jpeg_huffman_pkg::*;

    logic   fetch_valid;
    logic   rollback;
    index_t rollback_index;

    coded_coef_if   coef_bus ();
    symbol_if       sym_bus ();
    table_lookup_if lookup_bus ();

    coefficient_fetch u_fetch (
        .clock(clock), .nreset(nreset), .start(start),
        .rollback(rollback), .rollback_index(rollback_index),
        .fetch_addr(fetch_addr), .fetch_valid(fetch_valid)
    );

    coefficient_categorizer u_categorizer (
        .clock(clock), .nreset(nreset),
        .fetch_addr(fetch_addr), .fetch_valid(fetch_valid), .rollback(rollback),
        .coef_data(coef_data), .coef(coef_bus.source)
    );

    run_length_coder u_rlc (
        .clock(clock), .nreset(nreset),
        .coef(coef_bus.sink), .sym(sym_bus.source), .lookup(lookup_bus.requester),
        .rollback(rollback), .rollback_index(rollback_index)
    );

    huffman_table_store u_tables (
        .clock(clock), .table_wren(table_wren), .table_waddr(table_waddr),
        .table_wcode(table_wcode), .table_wlength(table_wlength),
        .lookup(lookup_bus.responder)
    );

    bitstream_packer u_packer (
        .clock(clock), .nreset(nreset),
        .sym(sym_bus.sink), .lookup(lookup_bus.reader),
        .output_wren(output_wren), .output_length(output_length),
        .output_data(output_data), .finished(finished)
    );

endmodule

// ==== design/jpeg_huffman_if.sv ====
`timescale 1ns/1ps

// categorized coefficient, one per cycle, no handshake
interface coded_coef_if;
    import jpeg_huffman_pkg::*;

    logic      valid;
    logic      is_dc;
    logic      is_last;
    index_t    index;
    code_t     value_bits;
    category_t category;

    modport source (output valid, is_dc, is_last, index, value_bits, category);
    modport sink (input valid, is_dc, is_last, index, value_bits, category);
endinterface

// symbol item, lined up with its table read at the packer
interface symbol_if;
    import jpeg_huffman_pkg::*;

    logic         valid;
    symbol_kind_t kind;
    logic         is_last;
    code_t        value_bits;
    category_t    category;

    modport source (output valid, kind, is_last, value_bits, category);
    modport sink (input valid, kind, is_last, value_bits, category);
endinterface

// code table read port, data one cycle after the address
interface table_lookup_if;
    import jpeg_huffman_pkg::*;

    table_addr_t rd_addr;
    code_t       rd_code;
    code_len_t   rd_length;

    modport requester (output rd_addr);
    modport reader (input rd_code, rd_length);
    modport responder (input rd_addr, output rd_code, rd_length);
endinterface

// ==== design/jpeg_huffman_params.svh ====
`ifndef JPEG_HUFFMAN_PARAMS_SVH
`define JPEG_HUFFMAN_PARAMS_SVH

// coefficient and block geometry
`define COEF_WIDTH        16
`define BLOCK_LEN         64
`define INDEX_WIDTH       6

// huffman table entries
`define CODE_WIDTH        16
`define CODE_LEN_WIDTH    5
`define CAT_WIDTH         4
`define SYMBOL_WIDTH      8
`define TABLE_ADDR_WIDTH  9

// packed output word
`define OUT_WIDTH         32
`define OUT_LEN_WIDTH     6

// run-length coding
`define ZRL_RUN           16
`define ZRL_SYMBOL        8'hf0
`define EOB_SYMBOL        8'h00

`endif

// ==== design/jpeg_huffman_pkg.sv ====
`include "jpeg_huffman_params.svh"

package jpeg_huffman_pkg;

    // quantized coefficient as read from the block memory
    typedef logic signed [`COEF_WIDTH-1:0] coef_t;

    // zig-zag position inside one 8x8 block
    typedef logic [`INDEX_WIDTH-1:0] index_t;

    // magnitude category, also the number of value bits
    typedef logic [`CAT_WIDTH-1:0] category_t;

    typedef logic [`CODE_WIDTH-1:0] code_t;
    typedef logic [`CODE_LEN_WIDTH-1:0] code_len_t;

    // msb selects the ac half of the table store
    typedef logic [`TABLE_ADDR_WIDTH-1:0] table_addr_t;

    typedef logic [`OUT_WIDTH-1:0] out_word_t;
    typedef logic [`OUT_LEN_WIDTH-1:0] out_len_t;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_RUN
    } fetch_state_t;

    // tells the packer how a word is built
    typedef enum logic [1:0] {
        SYM_DC,
        SYM_AC,
        SYM_ZRL,
        SYM_EOB
    } symbol_kind_t;

endpackage

// ==== design/run_length_coder.sv ====
`timescale 1ns/1ps
`include "jpeg_huffman_params.svh"

module run_length_coder (
    input  logic                     clock,
    input  logic                     nreset,
    coded_coef_if.sink               coef,
    symbol_if.source                 sym,
    table_lookup_if.requester        lookup,
    output logic                     rollback,
    output jpeg_huffman_pkg::index_t rollback_index
);
    import jpeg_huffman_pkg::*;

    index_t                   zero_count;
    logic                     is_zero;
    logic                     emit;
    symbol_kind_t             kind;
    logic [`SYMBOL_WIDTH-1:0] symbol;

    ////////////////////////////////////////////////////////////////////////////
    // symbol decision

    always_comb begin
        is_zero = (coef.category == '0);

        // a nonzero behind sixteen or more zeros becomes a zrl and is refetched
        rollback = coef.valid && !coef.is_dc && !is_zero
                   && (zero_count >= index_t'(`ZRL_RUN));
        rollback_index = coef.index - zero_count + index_t'(`ZRL_RUN);

        emit = coef.valid;
        if (coef.is_dc) begin
            kind = SYM_DC;
            symbol = `SYMBOL_WIDTH'(coef.category);
        end else if (rollback) begin
            kind = SYM_ZRL;
            symbol = `ZRL_SYMBOL;
        end else if (is_zero) begin
            // zeros are silent except in the last position
            kind = SYM_EOB;
            symbol = `EOB_SYMBOL;
            emit = coef.valid && coef.is_last;
        end else begin
            kind = SYM_AC;
            symbol = {zero_count[3:0], coef.category};
        end

        // select bit picks the ac half of the store
        lookup.rd_addr = {!coef.is_dc, symbol};
    end

    ////////////////////////////////////////////////////////////////////////////
    // zero run counter

    always_ff @(posedge clock) begin
        if (nreset) begin
            zero_count <= '0;
        end else if (coef.valid) begin
            if (coef.is_dc || rollback || !is_zero) begin
                zero_count <= '0;
            end else begin
                zero_count <= zero_count + 1'b1;
            end
        end
    end

    // registered alongside the table read so both reach the packer together
    always_ff @(posedge clock) begin
        if (nreset) begin
            sym.valid <= 1'b0;
        end else begin
            sym.valid <= emit;
        end
        sym.kind <= kind;
        sym.is_last <= coef.is_last;
        sym.value_bits <= coef.value_bits;
        sym.category <= coef.category;
    end

    // the item behind a zrl must be dropped by the categorizer
    assert property (@(posedge clock) disable iff (nreset) rollback |=> !coef.valid)
        else $error("item behind a zrl was kept after rollback");

endmodule

// ==== tb/jpeg_huffman_model.svh ====
`ifndef JPEG_HUFFMAN_MODEL_SVH
`define JPEG_HUFFMAN_MODEL_SVH

// bits needed for the magnitude, the jpeg size category
function automatic int size_category(input int value);
    int magnitude;
    int bits;
    magnitude = (value < 0) ? -value : value;
    bits = 0;
    while (magnitude != 0) begin
        bits++;
        magnitude = magnitude >> 1;
    end
    return bits;
endfunction

// negative values are sent as value minus one, low bits only
function automatic int value_field(input int value, input int bits);
    int mask;
    mask = (1 << bits) - 1;
    return (value < 0) ? ((value - 1) & mask) : (value & mask);
endfunction

// code in the low bits, value bits straight above it
function automatic void expect_word(input int addr, input int vbits, input int vlen);
    int          len;
    logic [31:0] code;
    len = int'(table_len[addr]);
    code = 32'(table_code[addr]) & ((32'd1 << len) - 32'd1);
    exp_data_q.push_back(code | (32'(vbits) << len));
    exp_len_q.push_back(out_len_t'(len + vlen));
endfunction

// expected words for the block in block_mem
function automatic void model_block();
    int diff;
    int bits;
    int run;
    int value;
    diff = int'(block_mem[0]) - model_dc_pred;
    model_dc_pred = int'(block_mem[0]);
    bits = size_category(diff);
    expect_word(bits, value_field(diff, bits), bits);
    run = 0;
    for (int k = 1; k < `BLOCK_LEN; k++) begin
        value = int'(block_mem[k]);
        if (value == 0) begin
            run++;
            // trailing zeros of any length collapse into one eob
            if (k == `BLOCK_LEN - 1) begin
                expect_word(AC_BASE + `EOB_SYMBOL, 0, 0);
            end
        end else begin
            while (run >= `ZRL_RUN) begin
                expect_word(AC_BASE + `ZRL_SYMBOL, 0, 0);
                run -= `ZRL_RUN;
            end
            bits = size_category(value);
            expect_word(AC_BASE + run * 16 + bits, value_field(value, bits), bits);
            run = 0;
        end
    end
endfunction

`endif

// ==== tb/jpeg_huffman_encode_tb.sv ====
`timescale 1ns/1ps
`include "jpeg_huffman_params.svh"

module jpeg_huffman_encode_tb;
    import jpeg_huffman_pkg::*;

    localparam int CLOCK_HALF = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 16;
    localparam int TABLE_DEPTH = 2 ** `TABLE_ADDR_WIDTH;
    localparam int AC_BASE = 2 ** `SYMBOL_WIDTH;
    localparam int NUM_BLOCKS = 30;
    localparam int FIRST_WORD_LATENCY = 4;
    localparam int RELOAD_DIFF = 21;
    // reset, table loads and a budget per block
    localparam int CYCLE_LIMIT = RESET_CYCLES + 2 * TABLE_DEPTH + NUM_BLOCKS * 200;

    logic        clock = 1'b0;
    logic        nreset;
    logic        start;
    index_t      fetch_addr;
    coef_t       coef_data;
    logic        table_wren;
    table_addr_t table_waddr;
    code_t       table_wcode;
    code_len_t   table_wlength;
    logic        output_wren;
    out_len_t    output_length;
    out_word_t   output_data;
    logic        finished;

    // host copies of the code tables, and the block memory
    code_t     table_code [TABLE_DEPTH];
    code_len_t table_len [TABLE_DEPTH];
    coef_t     block_mem [`BLOCK_LEN];
    index_t    addr_hold = '0;

    out_word_t exp_data_q [$];
    out_len_t  exp_len_q [$];
    int        model_dc_pred;

    int        cycle_count = 0;
    int        error_count = 0;
    int        words_checked = 0;
    int        blocks_done = 0;
    int        start_cycle = 0;
    logic      first_word_pending = 1'b0;
    logic      finished_q = 1'b0;
    out_word_t exp_data;
    out_len_t  exp_len;

    `include "jpeg_huffman_model.svh"

    jpeg_huffman_encode DUT (
        .clock(clock), .nreset(nreset), .start(start),
        .fetch_addr(fetch_addr), .coef_data(coef_data),
        .table_wren(table_wren), .table_waddr(table_waddr),
        .table_wcode(table_wcode), .table_wlength(table_wlength),
        .output_wren(output_wren), .output_length(output_length),
        .output_data(output_data), .finished(finished)
    );

    always #CLOCK_HALF clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // coefficient memory returns data one edge after the address

    always @(negedge clock) begin
        addr_hold = fetch_addr;
    end

    initial begin
        coef_data = '0;
        forever begin
            @(posedge clock);
            #DRIVE_DELAY;
            coef_data = block_mem[addr_hold];
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d blocks finished",
                     cycle_count, blocks_done, NUM_BLOCKS);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs are compared mid cycle

    always @(negedge clock) begin
        if (start) begin
            start_cycle = cycle_count + 1;
            first_word_pending = 1'b1;
        end
        // the sweep begins at zig-zag position zero right after start
        if (first_word_pending && cycle_count == start_cycle && fetch_addr !== '0) begin
            $display("ERR fetch_addr: expected %h got %h (block %0d)",
                     index_t'(0), fetch_addr, blocks_done);
            error_count++;
        end
        if (output_wren) begin
            if (first_word_pending && cycle_count - start_cycle != FIRST_WORD_LATENCY) begin
                $display("first word of block %0d came %0d cycles after start",
                         blocks_done, cycle_count - start_cycle);
                error_count++;
            end
            first_word_pending = 1'b0;
            if (exp_data_q.size() == 0) begin
                $display("output word %h in block %0d was not expected",
                         output_data, blocks_done);
                error_count++;
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_len = exp_len_q.pop_front();
                words_checked++;
                if (output_data !== exp_data) begin
                    $display("ERR output_data: expected %h got %h (block %0d)",
                             exp_data, output_data, blocks_done);
                    error_count++;
                end
                if (output_length !== exp_len) begin
                    $display("ERR output_length: expected %h got %h (block %0d)",
                             exp_len, output_length, blocks_done);
                    error_count++;
                end
            end
        end
        // every expected word must have been seen by the end of the block
        if (finished && !finished_q) begin
            if (exp_data_q.size() != 0) begin
                $display("block %0d finished with %0d words still missing",
                         blocks_done, exp_data_q.size());
                error_count++;
                exp_data_q.delete();
                exp_len_q.delete();
            end
            blocks_done++;
        end
        finished_q = finished;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers

    function automatic coef_t random_coef();
        int bits;
        int mag;
        bits = int'($urandom % 10) + 1;
        mag = 1 + int'($urandom % ((32'd1 << bits) - 32'd1));
        if ($urandom % 2 == 1) begin
            mag = -mag;
        end
        return coef_t'(mag);
    endfunction

    task automatic write_table_entry(input int addr, input code_t code, input code_len_t len);
        @(posedge clock);
        #DRIVE_DELAY;
        table_wren = 1'b1;
        table_waddr = table_addr_t'(addr);
        table_wcode = code;
        table_wlength = len;
        table_code[addr] = code;
        table_len[addr] = len;
    endtask

    task automatic stop_table_writes();
        @(posedge clock);
        #DRIVE_DELAY;
        table_wren = 1'b0;
    endtask

    // random codes of length 1 to 16 in every dc and ac entry
    task automatic load_all_tables();
        for (int a = 0; a < TABLE_DEPTH; a++) begin
            write_table_entry(a, code_t'($urandom), code_len_t'(1 + $urandom % 16));
        end
        stop_table_writes();
    endtask

    task automatic clear_block(input int dc);
        block_mem[0] = coef_t'(dc);
        for (int k = 1; k < `BLOCK_LEN; k++) begin
            block_mem[k] = '0;
        end
    endtask

    task automatic fill_random_block();
        block_mem[0] = random_coef();
        for (int k = 1; k < `BLOCK_LEN; k++) begin
            block_mem[k] = ($urandom % 6 == 0) ? random_coef() : '0;
        end
    endtask

    // start pulse, then wait for the block's finished edge
    task automatic run_block();
        int target;
        target = blocks_done + 1;
        model_block();
        @(posedge clock);
        #DRIVE_DELAY;
        start = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        start = 1'b0;
        while (blocks_done < target) begin
            @(posedge clock);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        void'($urandom(32'hfaa4_5774));
        nreset = 1'b1;
        start = 1'b0;
        table_wren = 1'b0;
        table_waddr = '0;
        table_wcode = '0;
        table_wlength = '0;
        model_dc_pred = 0;
        clear_block(0);

        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        nreset = 1'b0;
        @(negedge clock);
        if (output_wren !== 1'b0) begin
            $display("ERR output_wren: expected %h got %h after reset", 1'b0, output_wren);
            error_count++;
        end
        if (finished !== 1'b0) begin
            $display("ERR finished: expected %h got %h after reset", 1'b0, finished);
            error_count++;
        end

        load_all_tables();

        // dc only blocks with differences up and down
        clear_block(100);
        run_block();
        clear_block(37);
        run_block();
        clear_block(-250);
        run_block();

        // zero runs of 16, 17 and 35 ahead of a nonzero
        clear_block(12);
        block_mem[17] = 3;
        run_block();
        clear_block(-4);
        block_mem[18] = -7;
        block_mem[21] = 1;
        run_block();
        clear_block(0);
        block_mem[36] = 200;
        run_block();

        // nonzero last coefficient, then a long trailing run
        clear_block(55);
        block_mem[1] = 4;
        block_mem[63] = -9;
        run_block();
        clear_block(55);
        block_mem[10] = 1;
        run_block();

        repeat (20) begin
            fill_random_block();
            run_block();
        end

        // same dc difference before and after a table reload
        clear_block(model_dc_pred + RELOAD_DIFF);
        run_block();
        write_table_entry(size_category(RELOAD_DIFF), code_t'($urandom),
                          code_len_t'(table_len[size_category(RELOAD_DIFF)] % 16 + 1));
        stop_table_writes();
        clear_block(model_dc_pred + RELOAD_DIFF);
        run_block();

        repeat (4) @(posedge clock);
        $display("blocks %0d, words checked %0d, errors %0d",
                 blocks_done, words_checked, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
+incdir+tb
design/jpeg_huffman_pkg.sv
design/jpeg_huffman_if.sv
design/coefficient_fetch.sv
design/coefficient_categorizer.sv
design/run_length_coder.sv
design/huffman_table_store.sv
design/bitstream_packer.sv
design/jpeg_huffman_encode.sv
tb/jpeg_huffman_encode_tb.sv
